//--- design/cpuPkg.sv
package cpuPkg;

  ////////////////////////////////////////////////////////////
  // Machine word and register types
  ////////////////////////////////////////////////////////////
  typedef logic [15:0] dataWord;  // One register or memory value
  typedef logic [3:0]  regIdx;    // Register number, $0 reads as zero

  // Instruction opcodes, the top nibble of every instruction word
  typedef enum logic [3:0] {
    opAdd = 4'h0,  // rd = rs + rt
    opSub = 4'h1,  // rd = rs - rt
    opXor = 4'h2,  // rd = rs ^ rt
    opAnd = 4'h3,  // rd = rs & rt
    opLw  = 4'h8,  // rd = mem[rs + offset]
    opSw  = 4'h9,  // mem[rs + offset] = rd
    opLlb = 4'ha,  // Low byte of rd replaced by the immediate
    opLhb = 4'hb,  // High byte of rd replaced by the immediate
    opNop = 4'hf   // No operation, any unused opcode behaves the same
  } opcodeT;

  // Operations carried from decode into the execute stage
  typedef enum logic [2:0] {
    aluAdd,   // Operand sum
    aluSub,   // Operand difference
    aluXor,
    aluAnd,
    aluAddr,  // Base register plus sign-extended offset
    aluLlb,   // Keep high byte of the first operand
    aluLhb    // Keep low byte of the first operand
  } aluOpT;

  // Register view, also used by loads and stores with rt as a signed offset
  typedef struct packed {
    opcodeT opcode;
    regIdx  rd;
    regIdx  rs;
    regIdx  rt;
  } regViewT;

  // Byte view used by LLB and LHB
  typedef struct packed {
    opcodeT     opcode;
    regIdx      rd;
    logic [7:0] imm;
  } byteViewT;

  // One instruction word, read through whichever view the opcode selects
  typedef union packed {
    regViewT  r;
    byteViewT b;
  } instrWord;

endpackage

//--- design/stageIf.sv
`timescale 1ns/1ps

////////////////////////////////////////////////////////////
// Decode/execute pipeline register
////////////////////////////////////////////////////////////
interface exStageIf
  import cpuPkg::*;
();
  logic    valid;      // Slot holds an instruction, low for a bubble
  aluOpT   aluOp;
  regIdx   srcReg1;    // First source, rd for LLB and LHB
  regIdx   srcReg2;    // Second source, rd for SW as its data source
  regIdx   destReg;
  logic    regWrite;
  logic    memRead;
  logic    memWrite;
  dataWord operand1;   // Register file value of srcReg1
  dataWord operand2;   // Register file value of srcReg2
  dataWord storeData;  // Store value before any bypass
  dataWord imm;        // Sign-extended offset or zero-extended byte

  modport exSrc (output valid, aluOp, srcReg1, srcReg2, destReg, regWrite, memRead,
                 memWrite, operand1, operand2, storeData, imm);
  modport exSink (input valid, aluOp, srcReg1, srcReg2, destReg, regWrite, memRead,
                  memWrite, operand1, operand2, storeData, imm);
  modport exHaz (input srcReg1, srcReg2, memWrite);
endinterface

////////////////////////////////////////////////////////////
// Execute/memory pipeline register
////////////////////////////////////////////////////////////
interface memStageIf
  import cpuPkg::*;
();
  logic    valid;
  regIdx   destReg;
  logic    regWrite;
  logic    memRead;
  logic    memWrite;
  regIdx   srcReg2;    // Store data source, checked for the MEM-to-MEM bypass
  dataWord result;     // ALU result or memory address
  dataWord storeData;  // Store value after the execute-stage bypass

  modport memSrc (output valid, destReg, regWrite, memRead, memWrite, srcReg2, result,
                  storeData);
  modport memSink (input valid, destReg, regWrite, memRead, memWrite, srcReg2, result,
                   storeData);
  modport memHaz (input valid, destReg, regWrite, memRead, memWrite, srcReg2);
endinterface

////////////////////////////////////////////////////////////
// Memory/write-back pipeline register
////////////////////////////////////////////////////////////
interface wbStageIf
  import cpuPkg::*;
();
  logic    valid;
  regIdx   destReg;
  logic    regWrite;
  dataWord value;  // Loaded word or ALU result

  modport wbSrc (output valid, destReg, regWrite, value);
  modport wbSink (input valid, destReg, regWrite, value);
endinterface

//--- design/regFile.sv
`timescale 1ns/1ps

module regFile
  import cpuPkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  regIdx   readReg1,
  input  regIdx   readReg2,
  output dataWord readData1,
  output dataWord readData2,
  input  logic    writeEnable,
  input  regIdx   writeReg,
  input  dataWord writeData
);

  dataWord [15:0] regs;  // Entry 0 is never written and stays zero after reset

  logic writeValid;  // A write that really lands in a register
  assign writeValid = writeEnable && (writeReg != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      regs <= '0;
    end else if (writeValid) begin
      regs[writeReg] <= writeData;
    end
  end

  // Write-through so decode sees a result in the same cycle it is written back
  assign readData1 = (writeValid && (writeReg == readReg1)) ? writeData : regs[readReg1];
  assign readData2 = (writeValid && (writeReg == readReg2)) ? writeData : regs[readReg2];

  // A write-back aimed at $0 must leave every register untouched
  property zeroWriteIgnored;
    @(posedge clk) disable iff (reset)
      (writeEnable && (writeReg == '0)) |=> $stable(regs);
  endproperty
  assert property (zeroWriteIgnored)
    else $error("regFile: write to $0 changed the register contents");

endmodule

//--- design/decodeStage.sv
`timescale 1ns/1ps

module decodeStage
  import cpuPkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    instrValid,   // High when instr holds a word to take this edge
  input  instrWord instr,
  output regIdx   rfReadReg1,
  output regIdx   rfReadReg2,
  input  dataWord rfReadData1,
  input  dataWord rfReadData2,
  exStageIf.exSrc exOut,        // Decode/execute register
  memStageIf.memHaz memView     // Older instruction, checked for load-use
);

  opcodeT  op;
  regIdx   src1, src2, dest;
  aluOpT   aluOp;
  logic    writes, isLoad, isStore;
  dataWord immVal;

  assign op = instr.r.opcode;  // Opcode sits in the same bits in both views

  ////////////////////////////////////////////////////////////
  // Field decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    src1    = '0;  // Unused sources read $0 and never match a bypass
    src2    = '0;
    dest    = '0;
    aluOp   = aluAdd;
    writes  = 1'b0;
    isLoad  = 1'b0;
    isStore = 1'b0;
    immVal  = {{12{instr.r.rt[3]}}, instr.r.rt};  // Signed offset for loads and stores
    case (op)
      opAdd, opSub, opXor, opAnd: begin
        src1   = instr.r.rs;
        src2   = instr.r.rt;
        dest   = instr.r.rd;
        writes = 1'b1;
        aluOp  = (op == opSub) ? aluSub : (op == opXor) ? aluXor :
                 (op == opAnd) ? aluAnd : aluAdd;
      end
      opLw: begin
        src1   = instr.r.rs;   // Base address
        dest   = instr.r.rd;
        writes = 1'b1;
        isLoad = 1'b1;
        aluOp  = aluAddr;
      end
      opSw: begin
        src1    = instr.r.rs;
        src2    = instr.r.rd;  // Data to store
        isStore = 1'b1;
        aluOp   = aluAddr;
      end
      opLlb, opLhb: begin
        src1   = instr.b.rd;   // Untouched byte comes from rd itself
        dest   = instr.b.rd;
        writes = 1'b1;
        aluOp  = (op == opLlb) ? aluLlb : aluLhb;
        immVal = {8'h00, instr.b.imm};
      end
      default: ;  // NOP and unused opcodes leave the defaults
    endcase
  end

  assign rfReadReg1 = src1;
  assign rfReadReg2 = src2;

  // Control clears on reset and for bubbles
  always_ff @(posedge clk) begin
    if (reset) begin
      exOut.valid    <= 1'b0;
      exOut.regWrite <= 1'b0;
      exOut.memRead  <= 1'b0;
      exOut.memWrite <= 1'b0;
    end else begin
      exOut.valid    <= instrValid;
      exOut.regWrite <= instrValid && writes;
      exOut.memRead  <= instrValid && isLoad;
      exOut.memWrite <= instrValid && isStore;
    end
  end

  always_ff @(posedge clk) begin
    exOut.aluOp     <= aluOp;
    exOut.srcReg1   <= src1;
    exOut.srcReg2   <= src2;
    exOut.destReg   <= dest;
    exOut.operand1  <= rfReadData1;
    exOut.operand2  <= rfReadData2;
    exOut.storeData <= rfReadData2;  // Same read port as operand2, SW has no ALU use for it
    exOut.imm       <= immVal;
  end

  // A load result is ready one stage too late for an ALU operand right behind it
  property noLoadUse;
    @(posedge clk) disable iff (reset)
      (memView.valid && memView.memRead && memView.regWrite && (memView.destReg != '0) &&
       exOut.valid)
      |-> (exOut.srcReg1 != memView.destReg) &&
          (exOut.memWrite || (exOut.srcReg2 != memView.destReg));
  endproperty
  assert property (noLoadUse)
    else $error("decodeStage: load-use hazard on register %0d", memView.destReg);

endmodule

//--- design/forwardingUnit.sv
`timescale 1ns/1ps

module forwardingUnit (
  exStageIf.exHaz   exView,     // Instruction now in execute
  memStageIf.memHaz memView,    // Execute/memory register
  wbStageIf.wbSink  wbView,     // Memory/write-back register
  output logic [1:0] forwardA,  // 2'b10 memory result, 2'b01 write-back value
  output logic [1:0] forwardB,
  output logic      forwardMemEx,  // Write-back value into the store data in execute
  output logic      forwardMem     // Write-back value into the store data in memory
);

  logic memWritesReg;  // Execute/memory instruction writes a real register
  logic wbWritesReg;   // Write-back instruction writes a real register
  logic exToExA, exToExB;
  logic memToExA, memToExB;
  logic memToMem;

  // $0 is never forwarded since it always reads as zero
  assign memWritesReg = memView.regWrite && (memView.destReg != '0);
  assign wbWritesReg  = wbView.regWrite && (wbView.destReg != '0);

  ////////////////////////////////////////////////////////////
  // EX-to-EX, result from the instruction just ahead
  ////////////////////////////////////////////////////////////
  assign exToExA = memWritesReg && (memView.destReg == exView.srcReg1);
  assign exToExB = memWritesReg && (memView.destReg == exView.srcReg2);

  ////////////////////////////////////////////////////////////
  // MEM-to-EX, result from two instructions ahead
  ////////////////////////////////////////////////////////////
  // The newer match wins when both older instructions wrote the same register
  assign memToExA = wbWritesReg && !exToExA && (wbView.destReg == exView.srcReg1);
  assign memToExB = wbWritesReg && !exToExB && (wbView.destReg == exView.srcReg2);

  // Store source in the memory stage written by the instruction right ahead of it
  assign memToMem = wbWritesReg && (wbView.destReg == memView.srcReg2);

  ////////////////////////////////////////////////////////////
  // Select outputs
  ////////////////////////////////////////////////////////////
  assign forwardA = exToExA  ? 2'b10 :
                    memToExA ? 2'b01 : 2'b00;
  assign forwardB = exToExB  ? 2'b10 :
                    memToExB ? 2'b01 : 2'b00;

  assign forwardMemEx = memToExB && exView.memWrite;  // SW data two behind its producer
  assign forwardMem   = memToMem;                     // Covers LW followed by SW of its result

  // Select code 3 has no source behind it in execute
  always_comb begin
    assert final ((forwardA != 2'b11) && (forwardB != 2'b11))
      else $error("forwardingUnit: illegal operand select A=%b B=%b", forwardA, forwardB);
  end

endmodule

//--- design/executeStage.sv
`timescale 1ns/1ps

module executeStage
  import cpuPkg::*;
(
  input  logic        clk,
  input  logic        reset,
  exStageIf.exSink    exIn,         // Decode/execute register
  wbStageIf.wbSink    wbView,       // Bypass value from write-back
  input  logic [1:0]  forwardA,
  input  logic [1:0]  forwardB,
  input  logic        forwardMemEx,
  memStageIf.memSrc   memOut        // Execute/memory register
);

  dataWord opA;       // First operand after bypass
  dataWord opB;       // Second operand after bypass
  dataWord stData;    // Store data after bypass
  dataWord aluOut;

  ////////////////////////////////////////////////////////////
  // Operand bypass
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (forwardA)
      2'b10:   opA = memOut.result;   // Instruction one ahead
      2'b01:   opA = wbView.value;    // Instruction two ahead
      default: opA = exIn.operand1;
    endcase
    case (forwardB)
      2'b10:   opB = memOut.result;
      2'b01:   opB = wbView.value;
      default: opB = exIn.operand2;
    endcase
  end

  // Store data follows the second source, a load ahead is fixed up in memory
  always_comb begin
    if (forwardB == 2'b10) begin
      stData = memOut.result;
    end else if (forwardMemEx) begin
      stData = wbView.value;
    end else begin
      stData = exIn.storeData;
    end
  end

  ////////////////////////////////////////////////////////////
  // ALU and address adder
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (exIn.aluOp)
      aluAdd:  aluOut = opA + opB;  // Wraps on overflow
      aluSub:  aluOut = opA - opB;
      aluXor:  aluOut = opA ^ opB;
      aluAnd:  aluOut = opA & opB;
      aluAddr: aluOut = opA + exIn.imm;
      aluLlb:  aluOut = {opA[15:8], exIn.imm[7:0]};
      aluLhb:  aluOut = {exIn.imm[7:0], opA[7:0]};
      default: aluOut = opA + opB;
    endcase
  end

  // Control of the execute/memory register
  always_ff @(posedge clk) begin
    if (reset) begin
      memOut.valid    <= 1'b0;
      memOut.regWrite <= 1'b0;
      memOut.memRead  <= 1'b0;
      memOut.memWrite <= 1'b0;
    end else begin
      memOut.valid    <= exIn.valid;
      memOut.regWrite <= exIn.regWrite;
      memOut.memRead  <= exIn.memRead;
      memOut.memWrite <= exIn.memWrite;
    end
  end

  // Payload of the execute/memory register
  always_ff @(posedge clk) begin
    memOut.destReg   <= exIn.destReg;
    memOut.srcReg2   <= exIn.srcReg2;
    memOut.result    <= aluOut;
    memOut.storeData <= stData;
  end

endmodule

//--- design/memoryStage.sv
`timescale 1ns/1ps

module memoryStage
  import cpuPkg::*;
#(
  parameter int memAddrBits = 8  // Data memory holds 2**memAddrBits words
) (
  input  logic                   clk,
  input  logic                   reset,
  memStageIf.memSink             memIn,
  input  logic                   forwardMem,
  wbStageIf.wbSrc                wbOut,
  output logic                   storeValid,
  output logic [memAddrBits-1:0] storeAddr,
  output dataWord                storeData
);

  localparam int memDepth = 1 << memAddrBits;

  dataWord mem [memDepth];
  logic [memAddrBits-1:0] addr;  // Word address, upper result bits ignored
  dataWord stData;
  dataWord loadData;

  assign addr = memIn.result[memAddrBits-1:0];

  // Load right ahead of this store leaves its value only in write-back
  assign stData   = forwardMem ? wbOut.value : memIn.storeData;
  assign loadData = mem[addr];  // Combinational read

  assign storeValid = memIn.valid && memIn.memWrite;
  assign storeAddr  = addr;
  assign storeData  = stData;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < memDepth; i++) begin
        mem[i] <= '0;
      end
    end else if (storeValid) begin
      mem[addr] <= stData;
    end
  end

  ////////////////////////////////////////////////////////////
  // Memory/write-back register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      wbOut.valid    <= 1'b0;
      wbOut.regWrite <= 1'b0;
    end else begin
      wbOut.valid    <= memIn.valid;
      wbOut.regWrite <= memIn.regWrite;
    end
    wbOut.destReg <= memIn.destReg;  // Payload, no reset
    wbOut.value   <= memIn.memRead ? loadData : memIn.result;
  end

  // Decode never marks one instruction as both load and store
  assert property (@(posedge clk) disable iff (reset)
                   memIn.valid |-> !(memIn.memRead && memIn.memWrite))
    else $error("memoryStage: load and store set together");

endmodule

//--- design/pipeCore.sv
`timescale 1ns/1ps

module pipeCore
  import cpuPkg::*;
#(
  parameter int memAddrBits = 8
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   instrValid,
  input  logic [15:0]            instr,
  output logic                   wbValid,     // Register write-back report, $0 included
  output logic [3:0]             wbReg,
  output logic [15:0]            wbData,
  output logic                   storeValid,
  output logic [memAddrBits-1:0] storeAddr,
  output logic [15:0]            storeData
);

  exStageIf  exBus();   // Decode/execute register
  memStageIf memBus();  // Execute/memory register
  wbStageIf  wbBus();   // Memory/write-back register

  regIdx      rfReadReg1, rfReadReg2;
  dataWord    rfReadData1, rfReadData2;
  logic [1:0] forwardA, forwardB;
  logic       forwardMemEx, forwardMem;
  logic       wbWrite;

  assign wbWrite = wbBus.valid && wbBus.regWrite;

  regFile uRegFile (
    .clk, .reset,
    .readReg1(rfReadReg1), .readReg2(rfReadReg2),
    .readData1(rfReadData1), .readData2(rfReadData2),
    .writeEnable(wbWrite), .writeReg(wbBus.destReg), .writeData(wbBus.value)
  );

  decodeStage uDecode (
    .clk, .reset, .instrValid, .instr,
    .rfReadReg1, .rfReadReg2, .rfReadData1, .rfReadData2,
    .exOut(exBus), .memView(memBus)
  );

  forwardingUnit uForward (
    .exView(exBus), .memView(memBus), .wbView(wbBus),
    .forwardA, .forwardB, .forwardMemEx, .forwardMem
  );

  executeStage uExecute (
    .clk, .reset, .exIn(exBus), .wbView(wbBus),
    .forwardA, .forwardB, .forwardMemEx, .memOut(memBus)
  );

  memoryStage #(.memAddrBits(memAddrBits)) uMemory (
    .clk, .reset, .memIn(memBus), .forwardMem, .wbOut(wbBus),
    .storeValid, .storeAddr, .storeData
  );

  // Write-back report leaves as plain ports
  assign wbValid = wbWrite;
  assign wbReg   = wbBus.destReg;
  assign wbData  = wbBus.value;

endmodule

//--- dv/pipeCoreTb.sv
`timescale 1ns/1ps

module pipeCoreTb
  import cpuPkg::*;
();

  localparam int memBits   = 8;     // Data memory address width of the DUT
  localparam int maxRecs   = 1024;  // Room for every expected report of one run
  localparam int randCount = 200;
  localparam logic [15:0] nopWord = 16'hf000;

  logic               clk;
  logic               reset;
  logic               instrValid;
  logic [15:0]        instr;
  logic               wbValid;
  logic [3:0]         wbReg;
  logic [15:0]        wbData;
  logic               storeValid;
  logic [memBits-1:0] storeAddr;
  logic [15:0]        storeData;

  pipeCore #(.memAddrBits(memBits)) DUT (
    .clk, .reset, .instrValid, .instr,
    .wbValid, .wbReg, .wbData,
    .storeValid, .storeAddr, .storeData
  );

  logic [15:0] refRegs [16];            // Architectural registers where entry 0 stays zero
  logic [15:0] refMem [1 << memBits];

  // Expected reports in program order along with the edge that took each instruction
  logic [3:0]         expWbReg [maxRecs];
  logic [15:0]        expWbData [maxRecs];
  int                 expWbEdge [maxRecs];
  logic [memBits-1:0] expStoreAddr [maxRecs];
  logic [15:0]        expStoreData [maxRecs];
  int                 expStoreEdge [maxRecs];

  int wbPushCount = 0;
  int wbPopCount = 0;      // Index of the oldest write-back still awaited
  int storePushCount = 0;
  int storePopCount = 0;
  int edgeCount = 0;       // Rising edges seen so far
  int wbErrors = 0;
  int storeErrors = 0;
  int otherErrors = 0;
  logic [31:0] rngState;

  always #2 clk = ~clk;  // 4 ns period

  always @(posedge clk) begin
    edgeCount <= edgeCount + 1;
    if (!reset && wbValid && (wbPopCount < wbPushCount)) begin
      wbPopCount <= wbPopCount + 1;  // Head moves on once its report is seen
    end
    if (!reset && storeValid && (storePopCount < storePushCount)) begin
      storePopCount <= storePopCount + 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks on the write-back and store reports
  ////////////////////////////////////////////////////////////
  assert property (@(posedge clk) (reset && (edgeCount > 0)) |-> (!wbValid && !storeValid))
    else begin
      otherErrors++;
      $display("A write-back or store report appeared while reset was held");
    end

  assert property (@(posedge clk) disable iff (reset) wbValid |-> (wbPopCount < wbPushCount))
    else begin
      wbErrors++;
      $display("A write-back report appeared with no instruction expecting one");
    end

  assert property (@(posedge clk) disable iff (reset)
                   (wbValid && (wbPopCount < wbPushCount)) |-> (wbReg == expWbReg[wbPopCount]))
    else begin
      wbErrors++;
      $display("Fail wbReg: got %h expected %h", $sampled(wbReg),
               expWbReg[$sampled(wbPopCount)]);
    end

  assert property (@(posedge clk) disable iff (reset)
                   (wbValid && (wbPopCount < wbPushCount)) |-> (wbData == expWbData[wbPopCount]))
    else begin
      wbErrors++;
      $display("Fail wbData: got %h expected %h", $sampled(wbData),
               expWbData[$sampled(wbPopCount)]);
    end

  // Pulse comes exactly three edges after the take edge and at no other edge
  assert property (@(posedge clk) disable iff (reset)
                   (wbPopCount < wbPushCount) |->
                   (wbValid == (edgeCount == expWbEdge[wbPopCount] + 2)))
    else begin
      wbErrors++;
      $display("Write-back for the instruction taken at edge %0d came at the wrong cycle",
               expWbEdge[$sampled(wbPopCount)]);
    end

  assert property (@(posedge clk) disable iff (reset)
                   storeValid |-> (storePopCount < storePushCount))
    else begin
      storeErrors++;
      $display("A store report appeared with no store expecting one");
    end

  assert property (@(posedge clk) disable iff (reset)
                   (storeValid && (storePopCount < storePushCount)) |->
                   (storeAddr == expStoreAddr[storePopCount]))
    else begin
      storeErrors++;
      $display("Fail storeAddr: got %h expected %h", $sampled(storeAddr),
               expStoreAddr[$sampled(storePopCount)]);
    end

  assert property (@(posedge clk) disable iff (reset)
                   (storeValid && (storePopCount < storePushCount)) |->
                   (storeData == expStoreData[storePopCount]))
    else begin
      storeErrors++;
      $display("Fail storeData: got %h expected %h", $sampled(storeData),
               expStoreData[$sampled(storePopCount)]);
    end

  // Store shows two edges after it is taken
  assert property (@(posedge clk) disable iff (reset)
                   (storePopCount < storePushCount) |->
                   (storeValid == (edgeCount == expStoreEdge[storePopCount] + 1)))
    else begin
      storeErrors++;
      $display("Store for the instruction taken at edge %0d came at the wrong cycle",
               expStoreEdge[$sampled(storePopCount)]);
    end

  ////////////////////////////////////////////////////////////
  // Instruction encoding and random stream
  ////////////////////////////////////////////////////////////
  function automatic logic [15:0] encodeReg(input opcodeT op, input logic [3:0] rd,
                                            input logic [3:0] rs, input logic [3:0] rt);
    return {op, rd, rs, rt};
  endfunction

  function automatic logic [15:0] encodeByte(input opcodeT op, input logic [3:0] rd,
                                             input logic [7:0] imm);
    return {op, rd, imm};
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [15:0] randomInstr(input logic [31:0] r);
    logic [3:0] rd;
    logic [3:0] rs;
    logic [3:0] rt;
    logic [3:0] off;
    logic [7:0] imm;
    rd  = {1'b0, r[6:4]};  // Eight registers keep dependencies frequent
    rs  = {1'b0, r[9:7]};
    rt  = {1'b0, r[12:10]};
    off = r[16:13];        // Signed word offset
    imm = r[23:16];
    case (r[31:28])
      4'h0, 4'h1:       return encodeReg(opAdd, rd, rs, rt);
      4'h2, 4'h3:       return encodeReg(opSub, rd, rs, rt);
      4'h4:             return encodeReg(opXor, rd, rs, rt);
      4'h5:             return encodeReg(opAnd, rd, rs, rt);
      4'h6, 4'h7, 4'h8: return encodeReg(opLw, rd, rs, off);
      4'h9, 4'ha, 4'hb: return encodeReg(opSw, rd, rs, off);
      4'hc:             return encodeByte(opLlb, rd, imm);
      4'hd:             return encodeByte(opLhb, rd, imm);
      default:          return nopWord;
    endcase
  endfunction

  // Register r feeds the ALU or address adder of word w while store data does not count
  function automatic logic readsAsOperand(input logic [15:0] w, input logic [3:0] r);
    case (w[15:12])
      opAdd, opSub, opXor, opAnd: return (w[7:4] == r) || (w[3:0] == r);
      opLw, opSw:                 return w[7:4] == r;
      opLlb, opLhb:               return w[11:8] == r;
      default:                    return 1'b0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Reference model stepping one instruction in program order
  ////////////////////////////////////////////////////////////
  task automatic modelStep(input logic [15:0] w);
    logic [3:0]  op;
    logic [3:0]  rd;
    logic [3:0]  rs;
    logic [3:0]  rt;
    logic [15:0] addrSum;
    logic [15:0] val;
    logic        writes;
    int          taken;
    op      = w[15:12];
    rd      = w[11:8];
    rs      = w[7:4];
    rt      = w[3:0];
    addrSum = refRegs[rs] + {{12{rt[3]}}, rt};
    taken   = edgeCount + 1;  // Driven now and taken at the next edge
    writes  = 1'b1;
    val     = '0;
    case (op)
      opAdd: val = refRegs[rs] + refRegs[rt];
      opSub: val = refRegs[rs] - refRegs[rt];
      opXor: val = refRegs[rs] ^ refRegs[rt];
      opAnd: val = refRegs[rs] & refRegs[rt];
      opLw:  val = refMem[addrSum[memBits-1:0]];
      opLlb: val = {refRegs[rd][15:8], w[7:0]};
      opLhb: val = {w[7:0], refRegs[rd][7:0]};
      opSw: begin
        writes = 1'b0;
        expStoreAddr[storePushCount] = addrSum[memBits-1:0];
        expStoreData[storePushCount] = refRegs[rd];
        expStoreEdge[storePushCount] = taken;
        storePushCount++;
        refMem[addrSum[memBits-1:0]] = refRegs[rd];
      end
      default: writes = 1'b0;  // NOP and unused opcodes
    endcase
    if (writes) begin
      expWbReg[wbPushCount]  = rd;  // Writes to $0 are still reported
      expWbData[wbPushCount] = val;
      expWbEdge[wbPushCount] = taken;
      wbPushCount++;
      if (rd != 4'd0) begin
        refRegs[rd] = val;
      end
    end
  endtask

  task automatic issue(input logic [15:0] word);
    @(posedge clk);
    #0.5;
    instrValid = 1'b1;
    instr      = word;
    modelStep(word);
  endtask

  task automatic bubble(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #0.5;
      instrValid = 1'b0;
      instr      = nopWord;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  initial begin
    logic [15:0] word;
    logic [3:0]  prevLoad;  // Destination of the load just issued or zero if there is none
    int          waitCycles;
    clk        = 1'b0;
    reset      = 1'b1;
    instrValid = 1'b0;
    instr      = nopWord;
    rngState   = 32'hbe29_da6b;
    for (int i = 0; i < 16; i++) begin
      refRegs[i] = '0;
    end
    for (int i = 0; i < (1 << memBits); i++) begin
      refMem[i] = '0;
    end
    repeat (16) @(posedge clk);
    #0.5;
    reset = 1'b0;

    // EX-to-EX chains including LLB then LHB on one register
    issue(encodeByte(opLlb, 4'd1, 8'h34));
    issue(encodeByte(opLhb, 4'd1, 8'h12));
    issue(encodeByte(opLlb, 4'd2, 8'h0f));
    issue(encodeReg(opAdd, 4'd3, 4'd1, 4'd2));  // r2 one back and r1 two back
    issue(encodeReg(opSub, 4'd4, 4'd3, 4'd1));
    issue(encodeReg(opXor, 4'd5, 4'd3, 4'd4));
    issue(encodeByte(opLlb, 4'd6, 8'h11));
    issue(encodeByte(opLhb, 4'd6, 8'h22));      // Both older ones write r6
    issue(encodeReg(opAnd, 4'd7, 4'd6, 4'd5));  // Newest r6 has to win
    issue(encodeByte(opLlb, 4'd8, 8'h55));
    issue(encodeByte(opLlb, 4'd9, 8'h66));
    issue(encodeReg(opAdd, 4'd10, 4'd8, 4'd9)); // r8 through MEM-to-EX
    issue(encodeReg(opSub, 4'd11, 4'd8, 4'd10));

    // Write-through at distance three and across bubbles
    issue(encodeByte(opLlb, 4'd12, 8'h77));
    issue(nopWord);
    issue(nopWord);
    issue(encodeReg(opAdd, 4'd13, 4'd12, 4'd12));
    issue(encodeByte(opLhb, 4'd14, 8'h99));
    bubble(2);
    issue(encodeReg(opXor, 4'd15, 4'd14, 4'd13));
    bubble(4);
    issue(encodeReg(opSub, 4'd15, 4'd15, 4'd1));

    // Store data bypass paths
    issue(encodeReg(opAdd, 4'd5, 4'd1, 4'd2));
    issue(encodeReg(opSw, 4'd5, 4'd0, 4'h0));   // Data one behind its producer
    issue(encodeReg(opXor, 4'd9, 4'd1, 4'd3));
    issue(nopWord);
    issue(encodeReg(opSw, 4'd9, 4'd0, 4'h1));   // Data two behind through forwardMemEx
    issue(encodeReg(opLw, 4'd10, 4'd0, 4'h0));
    issue(encodeReg(opSw, 4'd10, 4'd0, 4'h2));  // Loaded value through forwardMem
    issue(encodeByte(opLlb, 4'd2, 8'h10));
    issue(encodeReg(opSw, 4'd13, 4'd2, 4'hf));  // Bypassed base with offset -1
    issue(encodeReg(opLw, 4'd4, 4'd2, 4'hf));   // Reads the word just stored
    issue(nopWord);
    issue(encodeReg(opAdd, 4'd6, 4'd4, 4'd4));
    issue(encodeReg(opLw, 4'd7, 4'd0, 4'h5));   // Untouched word is zero
    bubble(1);
    issue(encodeReg(opAdd, 4'd7, 4'd7, 4'd1));

    // $0 is reported but never kept or forwarded
    issue(encodeReg(opAdd, 4'd0, 4'd1, 4'd2));
    issue(encodeReg(opAdd, 4'd8, 4'd0, 4'd1));
    issue(encodeByte(opLlb, 4'd0, 8'haa));
    issue(nopWord);
    issue(encodeReg(opSw, 4'd0, 4'd0, 4'h3));
    issue(encodeReg(opLw, 4'd0, 4'd1, 4'h0));
    issue(encodeReg(opXor, 4'd9, 4'd0, 4'd0));
    bubble(1);

    // Random stream with a NOP wherever a load result is needed right away
    prevLoad = '0;
    for (int i = 0; i < randCount; i++) begin
      rngState = xorshift(rngState);
      word     = randomInstr(rngState);
      if (rngState[27:24] == 4'h0) begin
        bubble(1);
        prevLoad = '0;
      end
      if ((prevLoad != 4'd0) && readsAsOperand(word, prevLoad)) begin
        issue(nopWord);
      end
      issue(word);
      prevLoad = (word[15:12] == opLw) ? word[11:8] : 4'd0;
    end
    bubble(1);

    waitCycles = 0;
    while (((wbPopCount < wbPushCount) || (storePopCount < storePushCount)) &&
           (waitCycles < 100)) begin
      @(posedge clk);
      waitCycles++;
    end
    if ((wbPopCount < wbPushCount) || (storePopCount < storePushCount)) begin
      otherErrors++;
      $display("Timeout with %0d write-back and %0d store reports still missing",
               wbPushCount - wbPopCount, storePushCount - storePopCount);
    end
    repeat (4) @(posedge clk);  // Late stray reports still reach the checks

    $display("Errors: write-back %0d, store %0d, other %0d",
             wbErrors, storeErrors, otherErrors);
    if ((wbErrors + storeErrors + otherErrors) == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
design/cpuPkg.sv
design/stageIf.sv
design/regFile.sv
design/decodeStage.sv
design/forwardingUnit.sv
design/executeStage.sv
design/memoryStage.sv
design/pipeCore.sv
dv/pipeCoreTb.sv

//--- Makefile
# Verilator build and run of the pipeline testbench
SRCS := $(shell grep '\.sv$$' compile.f)

.PHONY: run clean

# Rebuilt only when the file list or a source changes
obj_dir/VpipeCoreTb: compile.f $(SRCS)
	verilator --binary --timing --assert --top-module pipeCoreTb -f compile.f -o VpipeCoreTb

# The log must hold the pass line and no fail line
run: obj_dir/VpipeCoreTb
	./obj_dir/VpipeCoreTb > sim.log 2>&1 || true
	cat sim.log
	grep -q "Result: PASSED" sim.log
	! grep -q "Result: FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
